//--- logic/irq_pkg.sv
// Interrupt subsystem definitions

`default_nettype none

package irq_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Largest supported line count
  parameter int unsigned MaxIrqs = 32;
  parameter int unsigned IdWidth = $clog2(MaxIrqs);

  // Interrupt id, one per line
  typedef logic [IdWidth-1:0] irq_id_t;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Controller states, as in the core's handshake
  typedef enum logic [1:0] {
    IRQ_IDLE    = 2'd0,
    IRQ_PENDING = 2'd1,
    IRQ_DONE    = 2'd2
  } irq_state_e;

  // Commands the core may issue
  typedef enum logic [2:0] {
    OP_TAKE    = 3'd0,
    OP_KILL    = 3'd1,
    OP_MRET    = 3'd2,
    OP_SET_MIE = 3'd3,
    OP_CLR_MIE = 3'd4,
    OP_WR_MASK = 3'd5
  } core_op_e;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // Request or taken event
  typedef struct packed {
    logic    valid;
    irq_id_t id;
  } irq_req_t;

  // Core command, data only meaningful for OP_WR_MASK
  typedef struct packed {
    core_op_e           op;
    logic [MaxIrqs-1:0] data;
  } core_cmd_t;

  // Machine status seen by the core
  typedef struct packed {
    logic    mie;
    logic    mpie;
    irq_id_t mcause;
  } status_t;

endpackage

`default_nettype wire

//--- logic/irq_prio_encoder.sv
// Interrupt line priority encoder

`default_nettype none

module irq_prio_encoder #(
  parameter int unsigned NumIrqs = 32
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Level-sensitive lines and per-line mask
  input  wire logic [NumIrqs-1:0]   irq_i,
  input  wire logic [NumIrqs-1:0]   mask_i,
  // Registered candidate toward the controller
  output irq_pkg::irq_req_t         cand_o
);

  logic [NumIrqs-1:0] active;
  irq_pkg::irq_req_t  cand_d;
  irq_pkg::irq_req_t  cand_q;

  // Only unmasked lines compete
  assign active = irq_i & mask_i;

  ////////////////////////////////////////////////////////////
  // Lowest index wins
  ////////////////////////////////////////////////////////////

  always_comb begin
    cand_d.valid = |active;
    cand_d.id    = '0;
    // Scan downward so the last hit is the lowest set bit
    for (int i = NumIrqs - 1; i >= 0; i--) begin
      if (active[i]) begin
        cand_d.id = irq_pkg::irq_id_t'(i);
      end
    end
  end

  // One cycle of latency, clean request for the FSM
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cand_q <= '0;
    end else begin
      cand_q <= cand_d;
    end
  end

  assign cand_o = cand_q;

endmodule

`default_nettype wire

//--- logic/irq_int_controller.sv
// Interrupt controller FSM

`default_nettype none

module irq_int_controller (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  // Candidate from the encoder
  input  irq_pkg::irq_req_t  cand_i,
  // Global enable from the trap block
  input  wire logic          mie_i,
  // One-cycle pulses from the trap block
  input  wire logic          take_i,
  input  wire logic          kill_i,
  // Offered interrupt and taken event
  output irq_pkg::irq_req_t  pend_o,
  output irq_pkg::irq_req_t  taken_o
);

  irq_pkg::irq_state_e state_d;
  irq_pkg::irq_state_e state_q;
  irq_pkg::irq_id_t    id_d;
  irq_pkg::irq_id_t    id_q;

  ////////////////////////////////////////////////////////////
  // State and latched id
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= irq_pkg::IRQ_IDLE;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    id_d    = id_q;
    unique case (state_q)
      irq_pkg::IRQ_IDLE: begin
        // Latch only while globally enabled
        if (cand_i.valid && mie_i) begin
          state_d = irq_pkg::IRQ_PENDING;
          id_d    = cand_i.id;
        end
      end
      irq_pkg::IRQ_PENDING: begin
        // Take wins over kill, id held stable
        if (take_i) begin
          state_d = irq_pkg::IRQ_DONE;
        end else if (kill_i) begin
          state_d = irq_pkg::IRQ_IDLE;
        end
      end
      irq_pkg::IRQ_DONE: begin
        state_d = irq_pkg::IRQ_IDLE;
      end
      default: begin
        state_d = irq_pkg::IRQ_IDLE;
      end
    endcase
  end

  // Request visible only while pending
  assign pend_o.valid  = (state_q == irq_pkg::IRQ_PENDING);
  assign pend_o.id     = id_q;

  // Taken event fires on the edge that enters done
  assign taken_o.valid = (state_q == irq_pkg::IRQ_PENDING) && take_i;
  assign taken_o.id    = id_q;

endmodule

`default_nettype wire

//--- logic/irq_trap_csr.sv
// Trap and status registers

`default_nettype none

module irq_trap_csr #(
  parameter int unsigned NumIrqs = 32
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Four-phase command port from the core
  input  wire logic                cmd_req_i,
  input  irq_pkg::core_cmd_t       cmd_i,
  output logic                     cmd_ack_o,
  // From the controller
  input  irq_pkg::irq_req_t        pend_i,
  input  irq_pkg::irq_req_t        taken_i,
  // To the controller and encoder
  output logic                     take_o,
  output logic                     kill_o,
  output logic                     mie_o,
  output logic [NumIrqs-1:0]       mask_o,
  // Toward the core
  output logic                     trap_req_o,
  output irq_pkg::irq_id_t         trap_id_o,
  output irq_pkg::status_t         status_o
);

  logic               ack_q;
  logic               cmd_new;
  logic               take_q;
  logic               kill_q;
  logic               mie_q;
  logic               mpie_q;
  irq_pkg::irq_id_t   mcause_q;
  logic [NumIrqs-1:0] mask_q;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Request seen with ack still low, runs once
  assign cmd_new = cmd_req_i && !ack_q;

  // Ack follows req one edge later, both ways
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q  <= 1'b0;
      take_q <= 1'b0;
      kill_q <= 1'b0;
    end else begin
      ack_q  <= cmd_req_i;
      // Single-cycle pulses toward the FSM
      take_q <= cmd_new && (cmd_i.op == irq_pkg::OP_TAKE);
      kill_q <= cmd_new && (cmd_i.op == irq_pkg::OP_KILL);
    end
  end

  ////////////////////////////////////////////////////////////
  // Status registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mcause_q <= '0;
    end else if (taken_i.valid) begin
      // Trap entry, overrides any enable write
      mcause_q <= taken_i.id;
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
    end else if (cmd_new) begin
      case (cmd_i.op)
        irq_pkg::OP_MRET: begin
          mie_q  <= mpie_q;
          mpie_q <= 1'b1;
        end
        irq_pkg::OP_SET_MIE: mie_q <= 1'b1;
        irq_pkg::OP_CLR_MIE: mie_q <= 1'b0;
        default: ;
      endcase
    end
  end

  // Mask comes up fully open
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '1;
    end else if (cmd_new && (cmd_i.op == irq_pkg::OP_WR_MASK)) begin
      mask_q <= cmd_i.data[NumIrqs-1:0];
    end
  end

  // Outputs
  assign cmd_ack_o       = ack_q;
  assign take_o          = take_q;
  assign kill_o          = kill_q;
  assign mie_o           = mie_q;
  assign mask_o          = mask_q;
  assign trap_req_o      = pend_i.valid;
  assign trap_id_o       = pend_i.id;
  assign status_o.mie    = mie_q;
  assign status_o.mpie   = mpie_q;
  assign status_o.mcause = mcause_q;

endmodule

`default_nettype wire

//--- logic/irq_subsys_top.sv
// Interrupt subsystem top level

`default_nettype none

module irq_subsys_top #(
  parameter int unsigned NumIrqs = 32
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // External interrupt lines
  input  wire logic [NumIrqs-1:0]  irq_i,
  // Core command port
  input  wire logic                cmd_req_i,
  input  irq_pkg::core_cmd_t       cmd_i,
  output logic                     cmd_ack_o,
  // Trap request and status to the core
  output logic                     trap_req_o,
  output irq_pkg::irq_id_t         trap_id_o,
  output irq_pkg::status_t         status_o
);

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  irq_pkg::irq_req_t  cand;
  irq_pkg::irq_req_t  pend;
  irq_pkg::irq_req_t  taken;
  logic               take;
  logic               kill;
  logic               mie;
  logic [NumIrqs-1:0] mask;

  // Line masking and selection
  irq_prio_encoder #(
    .NumIrqs (NumIrqs)
  ) u_encoder (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .irq_i  (irq_i),
    .mask_i (mask),
    .cand_o (cand)
  );

  // Pending and done handshake
  irq_int_controller u_controller (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cand_i  (cand),
    .mie_i   (mie),
    .take_i  (take),
    .kill_i  (kill),
    .pend_o  (pend),
    .taken_o (taken)
  );

  // Command decode and status
  irq_trap_csr #(
    .NumIrqs (NumIrqs)
  ) u_trap_csr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_req_i  (cmd_req_i),
    .cmd_i      (cmd_i),
    .cmd_ack_o  (cmd_ack_o),
    .pend_i     (pend),
    .taken_i    (taken),
    .take_o     (take),
    .kill_o     (kill),
    .mie_o      (mie),
    .mask_o     (mask),
    .trap_req_o (trap_req_o),
    .trap_id_o  (trap_id_o),
    .status_o   (status_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
// Testbench clock and reset

`default_nettype none

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 50,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  // Free-running 100 ns clock
  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  // Reset held over the first cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_irq_subsys.sv
// Interrupt subsystem testbench

`default_nettype none

module tb_irq_subsys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NumIrqs         = 32;
  localparam int unsigned CyclesPerRecord = 50;
  localparam int unsigned AckLimit        = 16;
  localparam int unsigned TrapLimit       = 16;
  localparam int unsigned Seed            = 32'hc758;
  localparam              StimFile        = "tests/irq_stimulus.txt";

  // Parsed stimulus line whose fields depend on its kind
  typedef struct packed {
    logic [7:0]  kind;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
  } record_t;

  logic               clk;
  logic               rst_n;
  logic [NumIrqs-1:0] irq;
  logic               cmd_req;
  irq_pkg::core_cmd_t cmd;
  logic               cmd_ack;
  logic               trap_req;
  irq_pkg::irq_id_t   trap_id;
  irq_pkg::status_t   status;

  record_t records[$];
  int      num_records     = 0;
  int      value_errors    = 0;
  int      protocol_errors = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  irq_subsys_top #(
    .NumIrqs (NumIrqs)
  ) dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .irq_i      (irq),
    .cmd_req_i  (cmd_req),
    .cmd_i      (cmd),
    .cmd_ack_o  (cmd_ack),
    .trap_req_o (trap_req),
    .trap_id_o  (trap_id),
    .status_o   (status)
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR at %0d ns: %s expected %b, actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input irq_pkg::irq_id_t exp,
                          input irq_pkg::irq_id_t act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR at %0d ns: %s expected %0d, actual %0d", $time, name, exp, act);
    end
  endtask

  // Fields shown as {mie,mpie,mcause}
  task automatic check_status(input string name, input irq_pkg::status_t exp,
                              input irq_pkg::status_t act);
    if (act !== exp) begin
      value_errors++;
      $display("ERROR at %0d ns: %s expected {%b,%b,%0d}, actual {%b,%b,%0d}",
               $time, name, exp.mie, exp.mpie, exp.mcause, act.mie, act.mpie, act.mcause);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Skips comment and blank lines
  task automatic load_records();
    int          fd;
    int          code;
    string       line;
    logic [7:0]  kind;
    logic [31:0] f [5];
    record_t     rec;
    fd = $fopen(StimFile, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          foreach (f[i]) f[i] = '0;
          code = $sscanf(line, "%c %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4]);
          rec = '{kind: kind, f1: f[0], f2: f[1], f3: f[2], f4: f[3], f5: f[4]};
          records.push_back(rec);
        end
      end
      $fclose(fd);
    end
    num_records = records.size();
  endtask

  // Random idle time long enough for a line to reach trap_req
  task automatic idle_gap();
    int n;
    n = 3 + ($urandom % 4);
    repeat (n) @(negedge clk);
  endtask

  // Four-phase req/ack with the core command port
  task automatic run_command(input irq_pkg::core_op_e op, input logic [31:0] data);
    int cycles;
    cmd.op   = op;
    cmd.data = data;
    cmd_req  = 1'b1;
    cycles   = 0;
    @(negedge clk);
    while (cmd_ack !== 1'b1 && cycles < AckLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_ack !== 1'b1) begin
      protocol_errors++;
      $display("Command %s at %0d ns was never acknowledged", op.name(), $time);
    end
    cmd_req = 1'b0;
    cycles  = 0;
    @(negedge clk);
    while (cmd_ack !== 1'b0 && cycles < AckLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (cmd_ack !== 1'b0) begin
      protocol_errors++;
      $display("Acknowledge of command %s at %0d ns never dropped", op.name(), $time);
    end
  endtask

  // Waits a bounded time on trap_req then checks id and status
  task automatic wait_and_check(input record_t rec);
    irq_pkg::status_t exp_status;
    int               cycles;
    exp_status.mie    = rec.f3[0];
    exp_status.mpie   = rec.f4[0];
    exp_status.mcause = irq_pkg::irq_id_t'(rec.f5);
    cycles            = 0;
    while (trap_req !== rec.f1[0] && cycles < TrapLimit) begin
      @(negedge clk);
      cycles++;
    end
    check_bit("trap_req_o", rec.f1[0], trap_req);
    // Id only meaningful while a request is offered
    if (rec.f1[0]) begin
      check_id("trap_id_o", irq_pkg::irq_id_t'(rec.f2), trap_id);
    end
    check_status("status_o", exp_status, status);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    irq     = '0;
    cmd_req = 1'b0;
    cmd     = '0;
    void'($urandom(Seed));
    load_records();
    if (num_records == 0) begin
      protocol_errors++;
      $display("No stimulus records could be read from %s", StimFile);
    end else begin
      wait (rst_n === 1'b1);
      @(negedge clk);
      check_bit("cmd_ack_o", 1'b0, cmd_ack);
      foreach (records[i]) begin
        case (records[i].kind)
          "L": begin
            irq = records[i].f1[NumIrqs-1:0];
            idle_gap();
          end
          "C": run_command(irq_pkg::core_op_e'(records[i].f1[2:0]), records[i].f2);
          "W": begin
            wait_and_check(records[i]);
            idle_gap();
          end
          default: begin
            protocol_errors++;
            $display("Stimulus record %0d has an unknown kind", i);
          end
        endcase
      end
    end
    $display("Errors: %0d value mismatches, %0d protocol failures",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog budget scales with the record count
  initial begin
    wait (num_records > 0);
    repeat (num_records * CyclesPerRecord) @(posedge clk);
    $display("Timeout: stimulus did not finish within %0d cycles",
             num_records * CyclesPerRecord);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/irq_stimulus.txt
# L lines(hex) | C op data(hex) | W trap_req trap_id mie mpie mcause(hex)
# Ops: 0 take, 1 kill, 2 mret, 3 set mie, 4 clr mie, 5 write mask
W 0 00 0 0 00
L 00000208
W 0 00 0 0 00
C 3 00000000
W 1 03 1 0 00
C 0 00000000
W 0 00 0 1 03
C 2 00000000
W 1 03 1 1 03
C 1 00000000
W 0 00 1 1 03
W 1 03 1 1 03
C 5 fffffff7
W 1 03 1 1 03
C 1 00000000
W 0 00 1 1 03
W 1 09 1 1 03
C 0 00000000
W 0 00 0 1 09
C 5 00000000
C 2 00000000
W 0 00 1 1 09
W 0 00 1 1 09
C 0 00000000
C 1 00000000
W 0 00 1 1 09
C 4 00000000
C 5 ffffffff
W 0 00 0 1 09
C 3 00000000
W 1 03 1 1 09
L 00000000
W 1 03 1 1 09
C 1 00000000
W 0 00 1 1 09

//--- irq_subsys_top.f
logic/irq_pkg.sv
logic/irq_prio_encoder.sv
logic/irq_int_controller.sv
logic/irq_trap_csr.sv
logic/irq_subsys_top.sv
tests/tb_clk_gen.sv
tests/tb_irq_subsys.sv

//--- Bender.yml
package:
  name: irq_subsys

sources:
  # RTL in compile order
  - logic/irq_pkg.sv
  - logic/irq_prio_encoder.sv
  - logic/irq_int_controller.sv
  - logic/irq_trap_csr.sv
  - logic/irq_subsys_top.sv
  # Testbench
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_irq_subsys.sv
